// File: Bender.yml
package:
  name: state_gate_vector

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - gate_types_pkg.sv
      - gate_ctrl_pkg.sv
      - gate_input_decode.sv
      - gate_fixed_mac.sv
      - gate_result_collect.sv
      - state_gate_vector.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_state_gate_vector.sv

// File: gate_ctrl_pkg.sv
//////////////////////////////
// Decode state enum
//////////////////////////////

`default_nettype none

package gate_ctrl_pkg;

  //////////////////////////////
  // Decode FSM
  //////////////////////////////

  typedef enum logic [1:0] {
    // Waiting for START
    DECODE_IDLE    = 2'd0,
    // Gathering operands of the current element
    DECODE_COLLECT = 2'd1,
    // All elements issued, waiting for READY
    DECODE_DRAIN   = 2'd2
  } decode_state_t;

endpackage

`default_nettype wire

// File: gate_fixed_mac.sv
//////////////////////////////
// Execute block: two-stage signed
// multiply-add with saturation
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "state_gate_settings.svh"

module gate_fixed_mac
  import gate_types_pkg::*;
(
  input  wire logic           CLK,
  input  wire logic           RST,
  input  wire gate_element_t  issue_element,
  input  wire logic           issue_valid,
  output gate_result_t        mac_result,
  output logic                mac_valid
);

  localparam int DW = `GATE_DATA_WIDTH;
  localparam int FB = `GATE_FRAC_BITS;
  // Full product and sum widths
  localparam int PW = 2 * DW;
  localparam int SW = PW + 1;

  //////////////////////////////
  // Stage one, products
  //////////////////////////////

  logic signed [PW-1:0] prod_fs, prod_ia;
  logic signed [PW-1:0] prod_fs_q, prod_ia_q;
  logic                 last_q1;
  logic                 valid_q1;
  logic                 marker;

  assign prod_fs = $signed(issue_element.f) * $signed(issue_element.s);
  assign prod_ia = $signed(issue_element.i) * $signed(issue_element.a);

  // Empty markers carry no operands
  assign marker = issue_valid && issue_element.empty;

  always_ff @(posedge CLK) begin
    prod_fs_q <= prod_fs;
    prod_ia_q <= prod_ia;
    last_q1   <= issue_element.last;
  end

  //////////////////////////////
  // Stage two, sum and clip
  //////////////////////////////

  logic signed [SW-1:0] sum;
  logic signed [SW-1:0] shifted;
  logic                 fits;
  logic [DW-1:0]        sat_value;
  gate_result_t         res_q;
  logic                 valid_q2;

  always_comb begin
    sum     = prod_fs_q + prod_ia_q;
    // Arithmetic shift, rounds toward minus infinity
    shifted = sum >>> FB;
    // In range when all bits above the result sign match it
    fits    = (shifted[SW-1:DW-1] == {(SW-DW+1){shifted[SW-1]}});
    if (fits)
      sat_value = shifted[DW-1:0];
    else if (shifted[SW-1])
      sat_value = {1'b1, {(DW-1){1'b0}}};
    else
      sat_value = {1'b0, {(DW-1){1'b1}}};
  end

  always_ff @(posedge CLK) begin
    res_q <= '{value: sat_value, overflow: !fits, last: last_q1, empty: 1'b0};
  end

  // Valid bits, one element may enter per cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q1 <= 1'b0;
      valid_q2 <= 1'b0;
    end else begin
      valid_q1 <= issue_valid && !issue_element.empty;
      valid_q2 <= valid_q1;
    end
  end

  //////////////////////////////
  // Output select
  //////////////////////////////

  // Marker skips both stages; pipeline is always empty behind a zero-length START
  always_comb begin
    if (marker)
      mac_result = '{value: '0, overflow: 1'b0, last: issue_element.last, empty: 1'b1};
    else
      mac_result = res_q;
  end

  assign mac_valid = valid_q2 || marker;

endmodule

`default_nettype wire

// File: gate_input_decode.sv
//////////////////////////////
// Decode block: operand capture per element,
// element counting and vector sequencing
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "state_gate_settings.svh"

module gate_input_decode
  import gate_types_pkg::*, gate_ctrl_pkg::*;
(
  input  wire logic                          CLK,
  input  wire logic                          RST,

  // Control
  input  wire logic                          START,
  input  wire logic                          READY,
  output logic                               accept_start,

  // Operands with their strobes
  input  wire logic [`GATE_LENGTH_WIDTH-1:0] SIZE_L_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   S_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   I_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   F_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   A_IN,
  input  wire logic                          S_IN_ENABLE,
  input  wire logic                          I_IN_ENABLE,
  input  wire logic                          F_IN_ENABLE,
  input  wire logic                          A_IN_ENABLE,

  // To execute
  output gate_element_t                      issue_element,
  output logic                               issue_valid
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  decode_state_t                  state;
  logic [`GATE_LENGTH_WIDTH-1:0]  len_q;
  logic [`GATE_LENGTH_WIDTH-1:0]  count;
  logic [`GATE_LENGTH_WIDTH-1:0]  count_next;

  // Captured operands of the element being built
  logic [`GATE_DATA_WIDTH-1:0]    f_q, s_q, i_q, a_q;
  logic [`GATE_DATA_WIDTH-1:0]    f_sel, s_sel, i_sel, a_sel;

  // Seen bits, order f s i a
  logic [3:0]                     seen;
  logic [3:0]                     seen_next;

  logic                           elem_done;
  logic                           elem_last;
  logic                           zero_len;

  //////////////////////////////
  // Element assembly
  //////////////////////////////

  assign accept_start = START && (state == DECODE_IDLE);
  assign zero_len     = (SIZE_L_IN == '0);

  always_comb begin
    // Same-cycle strobes win over stored values
    f_sel      = F_IN_ENABLE ? F_IN : f_q;
    s_sel      = S_IN_ENABLE ? S_IN : s_q;
    i_sel      = I_IN_ENABLE ? I_IN : i_q;
    a_sel      = A_IN_ENABLE ? A_IN : a_q;
    seen_next  = seen | {F_IN_ENABLE, S_IN_ENABLE, I_IN_ENABLE, A_IN_ENABLE};
    elem_done  = (state == DECODE_COLLECT) && (&seen_next);
    count_next = count + 1'b1;
    // Last when this element brings the count up to the length
    elem_last  = (count_next == len_q);
  end

  // Operand capture, repeated strobes overwrite
  always_ff @(posedge CLK) begin
    if (state == DECODE_COLLECT) begin
      if (F_IN_ENABLE)
        f_q <= F_IN;
      if (S_IN_ENABLE)
        s_q <= S_IN;
      if (I_IN_ENABLE)
        i_q <= I_IN;
      if (A_IN_ENABLE)
        a_q <= A_IN;
    end
  end

  //////////////////////////////
  // Sequencing FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= DECODE_IDLE;
      len_q       <= '0;
      count       <= '0;
      seen        <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= 1'b0;
      case (state)
        DECODE_IDLE: begin
          if (START) begin
            len_q <= SIZE_L_IN;
            count <= '0;
            seen  <= '0;
            // Zero length goes straight to drain with a marker
            if (zero_len) begin
              state       <= DECODE_DRAIN;
              issue_valid <= 1'b1;
            end else begin
              state <= DECODE_COLLECT;
            end
          end
        end
        DECODE_COLLECT: begin
          if (elem_done) begin
            seen        <= '0;
            count       <= count_next;
            issue_valid <= 1'b1;
            if (elem_last)
              state <= DECODE_DRAIN;
          end else begin
            seen <= seen_next;
          end
        end
        DECODE_DRAIN: begin
          // Result side has shown the last element
          if (READY)
            state <= DECODE_IDLE;
        end
        default: state <= DECODE_IDLE;
      endcase
    end
  end

  // Issued element payload
  always_ff @(posedge CLK) begin
    if (elem_done) begin
      issue_element <= '{f: f_sel, s: s_sel, i: i_sel, a: a_sel,
                         last: elem_last, empty: 1'b0};
    end else if (accept_start && zero_len) begin
      issue_element <= '{f: '0, s: '0, i: '0, a: '0, last: 1'b1, empty: 1'b1};
    end
  end

endmodule

`default_nettype wire

// File: gate_result_collect.sv
//////////////////////////////
// Result block: output strobe,
// completion pulse, sticky overflow
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "state_gate_settings.svh"

module gate_result_collect
  import gate_types_pkg::*;
(
  input  wire logic                        CLK,
  input  wire logic                        RST,

  // Accepted START from decode
  input  wire logic                        accept_start,

  // From execute
  input  wire gate_result_t                mac_result,
  input  wire logic                        mac_valid,

  // External
  output logic [`GATE_DATA_WIDTH-1:0]      S_OUT,
  output logic                             S_OUT_ENABLE,
  output logic                             READY,
  output logic                             OVERFLOW
);

  //////////////////////////////
  // Qualifiers
  //////////////////////////////

  logic has_value;
  logic clipped;

  // Real result, not a zero-length marker
  assign has_value = mac_valid && !mac_result.empty;
  assign clipped   = has_value && mac_result.overflow;

  //////////////////////////////
  // Strobes and flags
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      S_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
      OVERFLOW     <= 1'b0;
    end else begin
      S_OUT_ENABLE <= has_value;
      // Completion on the last element, empty or not
      READY        <= mac_valid && mac_result.last;
      // Sticky across the vector
      if (accept_start)
        OVERFLOW <= 1'b0;
      else if (clipped)
        OVERFLOW <= 1'b1;
    end
  end

  // Output value
  always_ff @(posedge CLK) begin
    if (has_value)
      S_OUT <= mac_result.value;
  end

endmodule

`default_nettype wire

// File: gate_types_pkg.sv
//////////////////////////////
// Packed structs for element operands
// and element results
//////////////////////////////

`default_nettype none

`include "state_gate_settings.svh"

package gate_types_pkg;

  // One element on its way into the multiply-add
  // Operands are signed Q values carried as raw bits
  typedef struct packed {
    logic [`GATE_DATA_WIDTH-1:0] f;
    logic [`GATE_DATA_WIDTH-1:0] s;
    logic [`GATE_DATA_WIDTH-1:0] i;
    logic [`GATE_DATA_WIDTH-1:0] a;
    // Final element of the vector
    logic                        last;
    // Marker only, no operands (zero length)
    logic                        empty;
  } gate_element_t;

  // One element after saturation
  typedef struct packed {
    logic [`GATE_DATA_WIDTH-1:0] value;
    // Result was clipped
    logic                        overflow;
    logic                        last;
    logic                        empty;
  } gate_result_t;

endpackage

`default_nettype wire

// File: project.f
+incdir+.
gate_types_pkg.sv
gate_ctrl_pkg.sv
gate_input_decode.sv
gate_fixed_mac.sv
gate_result_collect.sv
state_gate_vector.sv
tb_state_gate_vector.sv

// File: state_gate_settings.svh
//////////////////////////////
// Width settings for the cell-state gate
// Q format and vector length
//////////////////////////////

`ifndef STATE_GATE_SETTINGS_SVH
`define STATE_GATE_SETTINGS_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Operand and result width, signed
`define GATE_DATA_WIDTH 16

// Fraction bits of the Q format
`define GATE_FRAC_BITS 8

//////////////////////////////
// Sequencing
//////////////////////////////

// Vector length and element counter
`define GATE_LENGTH_WIDTH 8

`endif

// File: state_gate_vector.sv
//////////////////////////////
// Cell-state gate top: decode,
// execute and result blocks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "state_gate_settings.svh"

module state_gate_vector
  import gate_types_pkg::*;
(
  input  wire logic                          CLK,
  input  wire logic                          RST,

  // Control
  input  wire logic                          START,
  output logic                               READY,
  output logic                               OVERFLOW,

  // Operands
  input  wire logic [`GATE_LENGTH_WIDTH-1:0] SIZE_L_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   S_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   I_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   F_IN,
  input  wire logic [`GATE_DATA_WIDTH-1:0]   A_IN,
  input  wire logic                          S_IN_ENABLE,
  input  wire logic                          I_IN_ENABLE,
  input  wire logic                          F_IN_ENABLE,
  input  wire logic                          A_IN_ENABLE,

  // Result
  output logic [`GATE_DATA_WIDTH-1:0]        S_OUT,
  output logic                               S_OUT_ENABLE
);

  gate_element_t issue_element;
  logic          issue_valid;
  gate_result_t  mac_result;
  logic          mac_valid;
  logic          accept_start;

  // Operand collection, READY closes the vector
  gate_input_decode decode0 (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .READY         (READY),
    .accept_start  (accept_start),
    .SIZE_L_IN     (SIZE_L_IN),
    .S_IN          (S_IN),
    .I_IN          (I_IN),
    .F_IN          (F_IN),
    .A_IN          (A_IN),
    .S_IN_ENABLE   (S_IN_ENABLE),
    .I_IN_ENABLE   (I_IN_ENABLE),
    .F_IN_ENABLE   (F_IN_ENABLE),
    .A_IN_ENABLE   (A_IN_ENABLE),
    .issue_element (issue_element),
    .issue_valid   (issue_valid)
  );

  // s = f*s_prev + i*a
  gate_fixed_mac mac0 (
    .CLK           (CLK),
    .RST           (RST),
    .issue_element (issue_element),
    .issue_valid   (issue_valid),
    .mac_result    (mac_result),
    .mac_valid     (mac_valid)
  );

  gate_result_collect result0 (
    .CLK           (CLK),
    .RST           (RST),
    .accept_start  (accept_start),
    .mac_result    (mac_result),
    .mac_valid     (mac_valid),
    .S_OUT         (S_OUT),
    .S_OUT_ENABLE  (S_OUT_ENABLE),
    .READY         (READY),
    .OVERFLOW      (OVERFLOW)
  );

endmodule

`default_nettype wire

// File: tb_state_gate_vector.sv
//////////////////////////////
// Testbench for the cell-state gate
// LFSR stimulus, reference model, output monitor
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "state_gate_settings.svh"

module tb_state_gate_vector
  import gate_types_pkg::*, gate_ctrl_pkg::*;
;

  localparam int     DW    = `GATE_DATA_WIDTH;
  localparam longint MAX_V = (64'sd1 <<< (DW - 1)) - 1;
  localparam longint MIN_V = -MAX_V - 1;

  // Expected element, tagged with the edge its last operand was driven on
  typedef struct packed {
    logic [DW-1:0] value;
    logic          ovf;
    logic          last;
    logic [31:0]   cyc;
  } exp_entry_t;

  logic                          CLK, RST, START;
  logic [`GATE_LENGTH_WIDTH-1:0] SIZE_L_IN;
  logic [DW-1:0]                 S_IN, I_IN, F_IN, A_IN, S_OUT;
  logic                          S_IN_ENABLE, I_IN_ENABLE, F_IN_ENABLE, A_IN_ENABLE;
  logic                          S_OUT_ENABLE, READY, OVERFLOW;

  logic [31:0]   lfsr, cyc, zero_cyc;
  logic          sticky;
  int            ready_count, out_count, clip_pos, clip_neg;
  // Operands in order f s i a
  logic [DW-1:0] op [4];
  exp_entry_t    exp_q [$];
  exp_entry_t    mon_entry;

  state_gate_vector dut0 (.*);

  always #10 CLK = ~CLK;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int          b;
    r = '0;
    for (b = 0; b < n; b++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // s = f*s_prev + i*a, floor by the Q scale, clamp to the data range
  function automatic exp_entry_t model_element(input logic [DW-1:0] f, s, i, a,
                                               input logic last, input logic [31:0] at);
    longint     q;
    exp_entry_t r;
    q = (longint'($signed(f)) * longint'($signed(s)) +
         longint'($signed(i)) * longint'($signed(a))) >>> `GATE_FRAC_BITS;
    r.last = last;
    r.cyc  = at;
    r.ovf  = (q > MAX_V) || (q < MIN_V);
    if (q > MAX_V)
      r.value = {1'b0, {(DW-1){1'b1}}};
    else if (q < MIN_V)
      r.value = {1'b1, {(DW-1){1'b0}}};
    else
      r.value = q[DW-1:0];
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %h got %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic drive_strobes(input logic [3:0] strobe);
    F_IN_ENABLE <= strobe[0];
    S_IN_ENABLE <= strobe[1];
    I_IN_ENABLE <= strobe[2];
    A_IN_ENABLE <= strobe[3];
    F_IN        <= op[0];
    S_IN        <= op[1];
    I_IN        <= op[2];
    A_IN        <= op[3];
  endtask

  //////////////////////////////
  // One vector
  //////////////////////////////

  // Mode 0 spread with stray STARTs, 1 one element per cycle, 2 near full scale
  task automatic run_vector(input int len, input int mode);
    logic [3:0]  seen;
    logic [3:0]  strobe;
    logic [31:0] rnd;
    exp_entry_t  ent;
    int          k, j, tries, waited, ready_before;
    @(posedge CLK);
    START     <= 1'b1;
    SIZE_L_IN <= len;
    // Strobes beside START land in IDLE
    rnd = take_bits(4);
    drive_strobes(rnd[3:0]);
    sticky       = 1'b0;
    out_count    = 0;
    ready_before = ready_count;
    zero_cyc     = (len == 0) ? cyc : 32'hffff_0000;
    @(posedge CLK);
    START <= 1'b0;
    drive_strobes(4'h0);
    @(posedge CLK);
    // Cleared by the accepted START
    check_value("OVERFLOW", 0, OVERFLOW);
    for (k = 0; k < len; k++) begin
      seen  = 4'h0;
      tries = 0;
      while (seen != 4'hf) begin
        @(posedge CLK);
        rnd    = take_bits(4);
        strobe = (mode == 1 || tries > 20) ? 4'hf : rnd[3:0];
        for (j = 0; j < 4; j++) begin
          if (strobe[j]) begin
            rnd = take_bits(DW + 1);
            // Repeats overwrite, so the model keeps the latest value
            if (mode == 2)
              op[j] = rnd[DW] ? {1'b0, {(DW-1){1'b1}}} - rnd[7:0]
                              : {1'b1, {(DW-1){1'b0}}} + rnd[7:0];
            else
              op[j] = rnd[DW-1:0];
          end
        end
        drive_strobes(strobe);
        // Stray START in mid-vector, must be dropped
        rnd = take_bits(3);
        START     <= (mode == 0) && (rnd[2:0] == 3'd0);
        SIZE_L_IN <= len + 5;
        seen = seen | strobe;
        tries++;
      end
      ent = model_element(op[0], op[1], op[2], op[3], k == len - 1, cyc);
      if (ent.ovf && ent.value[DW-1])
        clip_neg++;
      else if (ent.ovf)
        clip_pos++;
      exp_q.push_back(ent);
    end
    if (len != 0) begin
      @(posedge CLK);
      START <= 1'b0;
      drive_strobes(4'h0);
    end
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
      if (waited > 200)
        stop_with_error("READY never arrived for the vector");
    end while (!READY);
    repeat (3) @(posedge CLK);
    check_value("READY count", ready_before + 1, ready_count);
    check_value("S_OUT_ENABLE count", len, out_count);
    check_value("pending elements", 0, exp_q.size());
    check_value("decode state", DECODE_IDLE, dut0.decode0.state);
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (!RST && S_OUT_ENABLE) begin
      if (exp_q.size() == 0) begin
        stop_with_error("S_OUT_ENABLE with no element outstanding");
      end else begin
        mon_entry = exp_q.pop_front();
        sticky    = sticky | mon_entry.ovf;
        out_count++;
        check_value("S_OUT", mon_entry.value, S_OUT);
        check_value("OVERFLOW", sticky, OVERFLOW);
        check_value("READY", mon_entry.last, READY);
        // Rises on the fourth edge after the drive edge, seen one edge later
        check_value("S_OUT_ENABLE cycle", mon_entry.cyc + 5, cyc);
      end
    end else if (!RST && READY) begin
      // Result-less completion, zero length only
      check_value("READY cycle", zero_cyc + 3, cyc);
    end
    if (!RST && READY)
      ready_count++;
  end

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    logic [31:0] rnd;
    int          v;
    lfsr        = 32'h61cc_40dc;
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    SIZE_L_IN   = '0;
    {S_IN, I_IN, F_IN, A_IN} = '0;
    {S_IN_ENABLE, I_IN_ENABLE, F_IN_ENABLE, A_IN_ENABLE} = '0;
    op          = '{default: '0};
    cyc         = '0;
    zero_cyc    = 32'hffff_0000;
    sticky      = 1'b0;
    ready_count = 0;
    out_count   = 0;
    clip_pos    = 0;
    clip_neg    = 0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    check_value("READY", 0, READY);
    check_value("S_OUT_ENABLE", 0, S_OUT_ENABLE);
    check_value("OVERFLOW", 0, OVERFLOW);
    check_value("issue_valid", 0, dut0.issue_valid);
    check_value("mac_valid", 0, dut0.mac_valid);
    check_value("decode state", DECODE_IDLE, dut0.decode0.state);
    // Operand strobes with no vector open
    repeat (5) begin
      @(posedge CLK);
      rnd = take_bits(4);
      op[rnd[1:0]] = rnd[3:2] ? 16'h7fff : 16'h8000;
      drive_strobes(rnd[3:0]);
    end
    run_vector(0, 0);
    run_vector(6, 1);
    run_vector(10, 2);
    run_vector(4, 0);
    for (v = 0; v < 30; v++) begin
      rnd = take_bits(7);
      run_vector(rnd[4:0] % 20 + 1, (rnd[6:5] == 2'd3) ? 0 : rnd[6:5]);
    end
    run_vector(0, 0);
    check_value("positive clip seen", 1, clip_pos != 0);
    check_value("negative clip seen", 1, clip_neg != 0);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
